// ==== verilog/color_pkg.sv ====
`default_nettype none

package color_pkg;

    // Raster timing, clk_read cycles per line and lines per frame
    localparam int H_ACTIVE     = 160;
    localparam int H_SYNC_START = 168;
    localparam int H_SYNC_END   = 184;
    localparam int H_TOTAL      = 200;

    localparam int V_ACTIVE     = 120;
    localparam int V_SYNC_START = 122;
    localparam int V_SYNC_END   = 124;
    localparam int V_TOTAL      = 130;

    // Wishbone port
    localparam int WB_ADDR_BITS = 16;     // Word address
    localparam int WB_DATA_BITS = 32;
    localparam int WB_CTRL_BIT  = 15;     // 1 selects control/status

    typedef logic [11:0] color12_t;       // {red, green, blue}, 4 bits each
    typedef logic [7:0]  fb_x_t;
    typedef logic [6:0]  fb_y_t;
    typedef logic [7:0]  h_count_t;
    typedef logic [7:0]  v_count_t;

    typedef enum logic {FB_A, FB_B} fb_select_t;

    typedef enum logic [1:0] {
        SWAP_IDLE,
        SWAP_ARMED,       // Waiting for the picture to leave blanking
        SWAP_WAIT_BLANK,  // Waiting for blanking to begin
        SWAP_PULSE
    } swap_state_t;

    typedef struct packed {
        fb_x_t x;
        fb_y_t y;
        logic  active;
        logic  hsync;
        logic  vsync;
        logic  vblank;
    } raster_t;

    typedef struct packed {
        color12_t color;
        logic     active;
        logic     hsync;
        logic     vsync;
    } video_t;

    typedef struct packed {
        fb_x_t    x;
        fb_y_t    y;
        color12_t color;
    } pixel_write_t;

endpackage

`default_nettype wire

// ==== verilog/raster_timer.sv ====
`default_nettype none
`timescale 1ns/1ps

module raster_timer (
    input  wire logic          clk_read,
    input  wire logic          rst,
    output color_pkg::raster_t raster
);

    color_pkg::h_count_t h_count;
    color_pkg::v_count_t v_count;
    logic                h_last;
    logic                v_last;

    assign h_last = (h_count == color_pkg::h_count_t'(color_pkg::H_TOTAL - 1));
    assign v_last = (v_count == color_pkg::v_count_t'(color_pkg::V_TOTAL - 1));

    always_ff @(posedge clk_read or posedge rst) begin
        if (rst) begin
            h_count <= '0;
            v_count <= '0;
        end else begin
            if (h_last) begin
                h_count <= '0;
                if (v_last) begin
                    v_count <= '0;        // Frame wrap
                end else begin
                    v_count <= v_count + 1'b1;
                end
            end else begin
                h_count <= h_count + 1'b1;
            end
        end
    end

    // Flags straight from the counter state
    always_comb begin
        raster.x = color_pkg::fb_x_t'(h_count);   // Valid only while active
        raster.y = color_pkg::fb_y_t'(v_count);

        raster.active =
            (h_count < color_pkg::h_count_t'(color_pkg::H_ACTIVE)) &&
            (v_count < color_pkg::v_count_t'(color_pkg::V_ACTIVE));

        // 16 clocks wide
        raster.hsync =
            (h_count >= color_pkg::h_count_t'(color_pkg::H_SYNC_START)) &&
            (h_count <  color_pkg::h_count_t'(color_pkg::H_SYNC_END));

        // Two lines wide
        raster.vsync =
            (v_count >= color_pkg::v_count_t'(color_pkg::V_SYNC_START)) &&
            (v_count <  color_pkg::v_count_t'(color_pkg::V_SYNC_END));

        raster.vblank = (v_count >= color_pkg::v_count_t'(color_pkg::V_ACTIVE));
    end

endmodule

`default_nettype wire

// ==== verilog/swap_sequencer.sv ====
`default_nettype none
`timescale 1ns/1ps

module swap_sequencer (
    input  wire logic clk_write,
    input  wire logic rst,
    input  wire logic swap_request,
    input  wire logic vblank,        // From the clk_read domain
    output logic      swap_busy,
    output logic      swap
);

    color_pkg::swap_state_t state;
    color_pkg::swap_state_t state_next;

    logic vblank_meta;
    logic vblank_sync;

    // Two-flop synchroniser for vblank
    always_ff @(posedge clk_write or posedge rst) begin
        if (rst) begin
            vblank_meta <= 1'b0;
            vblank_sync <= 1'b0;
        end else begin
            vblank_meta <= vblank;
            vblank_sync <= vblank_meta;
        end
    end

    always_ff @(posedge clk_write or posedge rst) begin
        if (rst) begin
            state <= color_pkg::SWAP_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        unique case (state)
            color_pkg::SWAP_IDLE: begin
                if (swap_request) begin
                    state_next = color_pkg::SWAP_ARMED;
                end
            end
            color_pkg::SWAP_ARMED: begin
                // A request inside blanking waits for the next one
                if (!vblank_sync) begin
                    state_next = color_pkg::SWAP_WAIT_BLANK;
                end
            end
            color_pkg::SWAP_WAIT_BLANK: begin
                if (vblank_sync) begin
                    state_next = color_pkg::SWAP_PULSE;
                end
            end
            color_pkg::SWAP_PULSE: begin
                state_next = color_pkg::SWAP_IDLE;
            end
            default: begin
                state_next = color_pkg::SWAP_IDLE;
            end
        endcase
    end

    // Requests outside IDLE are absorbed
    assign swap_busy = (state != color_pkg::SWAP_IDLE);
    assign swap      = (state == color_pkg::SWAP_PULSE);

endmodule

`default_nettype wire

// ==== verilog/wb_pixel_port.sv ====
`default_nettype none
`timescale 1ns/1ps

module wb_pixel_port (
    input  wire logic                                clk_write,
    input  wire logic                                rst,
    input  wire logic                                wb_cyc,
    input  wire logic                                wb_stb,
    input  wire logic                                wb_we,
    input  wire logic [color_pkg::WB_ADDR_BITS-1:0]  wb_adr,
    input  wire logic [color_pkg::WB_DATA_BITS-1:0]  wb_dat_w,
    output logic      [color_pkg::WB_DATA_BITS-1:0]  wb_dat_r,
    output logic                                     wb_ack,
    input  wire logic                                swap_busy,
    input  wire color_pkg::fb_select_t               back_buffer,
    output color_pkg::pixel_write_t                  pixel,
    output logic                                     pixel_we,
    output logic                                     swap_request
);

    logic                               ctrl_sel;
    logic                               pixel_wr;
    logic                               accept;
    logic [color_pkg::WB_DATA_BITS-1:0] status_word;

    assign ctrl_sel = wb_adr[color_pkg::WB_CTRL_BIT];
    assign pixel_wr = wb_we && !ctrl_sel;

    // New access, held off only for a pixel write during a pending swap
    assign accept = wb_cyc && wb_stb && !wb_ack && !(pixel_wr && swap_busy);

    always_comb begin
        status_word    = '0;
        status_word[0] = swap_busy;
        status_word[1] = (back_buffer == color_pkg::FB_B);
    end

    always_ff @(posedge clk_write or posedge rst) begin
        if (rst) begin
            wb_ack       <= 1'b0;
            pixel_we     <= 1'b0;
            swap_request <= 1'b0;
        end else begin
            wb_ack       <= accept;
            pixel_we     <= accept && pixel_wr;  // Same cycle as ack
            swap_request <= accept && wb_we && ctrl_sel && wb_dat_w[0];
        end
    end

    always_ff @(posedge clk_write) begin
        if (accept && pixel_wr) begin
            pixel.x     <= wb_adr[7:0];
            pixel.y     <= wb_adr[14:8];
            pixel.color <= wb_dat_w[11:0];
        end
        if (accept) begin
            wb_dat_r <= (ctrl_sel && !wb_we) ? status_word : '0;  // Memory not readable
        end
    end

endmodule

`default_nettype wire

// ==== verilog/double_framebuffer.sv ====
`default_nettype none
`timescale 1ns/1ps

module double_framebuffer #(
    parameter int FB_WIDTH  = color_pkg::H_ACTIVE,
    parameter int FB_HEIGHT = color_pkg::V_ACTIVE
) (
    input  wire logic                   clk_write,
    input  wire logic                   clk_read,
    input  wire logic                   rst,
    input  wire logic                   swap,         // One clk_write cycle
    input  wire logic                   pixel_we,
    input  wire color_pkg::pixel_write_t pixel,
    input  wire color_pkg::fb_x_t       read_x,
    input  wire color_pkg::fb_y_t       read_y,
    output color_pkg::color12_t         read_data,
    output color_pkg::fb_select_t       back_buffer
);

    localparam int FB_DEPTH   = FB_WIDTH * FB_HEIGHT;
    localparam int ADDR_WIDTH = $clog2(FB_DEPTH);

    logic [ADDR_WIDTH-1:0] write_addr;
    logic [ADDR_WIDTH-1:0] read_addr;

    // Row-major linear addresses
    assign write_addr = ADDR_WIDTH'(pixel.y) * ADDR_WIDTH'(FB_WIDTH) + ADDR_WIDTH'(pixel.x);
    assign read_addr  = ADDR_WIDTH'(read_y) * ADDR_WIDTH'(FB_WIDTH) + ADDR_WIDTH'(read_x);

    color_pkg::fb_select_t write_select;
    color_pkg::fb_select_t read_select;

    logic front_toggle;   // High while B is displayed
    logic front_meta;
    logic front_sync;

    always_ff @(posedge clk_write or posedge rst) begin
        if (rst) begin
            front_toggle <= 1'b0;
            write_select <= color_pkg::FB_B;
        end else if (swap) begin
            front_toggle <= ~front_toggle;
            write_select <= (write_select == color_pkg::FB_A) ? color_pkg::FB_B
                                                              : color_pkg::FB_A;
        end
    end

    assign back_buffer = write_select;

    // Select reaches the mux 3 clk_read cycles after the toggle
    always_ff @(posedge clk_read or posedge rst) begin
        if (rst) begin
            front_meta  <= 1'b0;
            front_sync  <= 1'b0;
            read_select <= color_pkg::FB_A;
        end else begin
            front_meta  <= front_toggle;
            front_sync  <= front_meta;
            read_select <= front_sync ? color_pkg::FB_B : color_pkg::FB_A;
        end
    end

    color_pkg::color12_t mem_a [0:FB_DEPTH-1];
    color_pkg::color12_t mem_b [0:FB_DEPTH-1];
    color_pkg::color12_t read_data_a;
    color_pkg::color12_t read_data_b;

    always_ff @(posedge clk_write) begin
        if (pixel_we && (write_select == color_pkg::FB_A)) begin
            mem_a[write_addr] <= pixel.color;
        end
        if (pixel_we && (write_select == color_pkg::FB_B)) begin
            mem_b[write_addr] <= pixel.color;
        end
    end

    // Both banks read every cycle
    always_ff @(posedge clk_read) begin
        read_data_a <= mem_a[read_addr];
        read_data_b <= mem_b[read_addr];
    end

    assign read_data = (read_select == color_pkg::FB_A) ? read_data_a : read_data_b;

endmodule

`default_nettype wire

// ==== verilog/video_output.sv ====
`default_nettype none
`timescale 1ns/1ps

module video_output (
    input  wire logic                clk_read,
    input  wire logic                rst,
    input  wire color_pkg::raster_t  raster,
    input  wire color_pkg::color12_t pixel_color,   // One cycle behind raster
    output color_pkg::video_t        video
);

    logic active_d;
    logic hsync_d;
    logic vsync_d;

    // Match the framebuffer read latency
    always_ff @(posedge clk_read or posedge rst) begin
        if (rst) begin
            active_d <= 1'b0;
            hsync_d  <= 1'b0;
            vsync_d  <= 1'b0;
        end else begin
            active_d <= raster.active;
            hsync_d  <= raster.hsync;
            vsync_d  <= raster.vsync;
        end
    end

    always_ff @(posedge clk_read or posedge rst) begin
        if (rst) begin
            video <= '0;
        end else begin
            video.color  <= active_d ? pixel_color : '0;   // Black outside the picture
            video.active <= active_d;
            video.hsync  <= hsync_d;
            video.vsync  <= vsync_d;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/video_subsystem.sv ====
`default_nettype none
`timescale 1ns/1ps

module video_subsystem (
    input  wire logic                                clk_write,
    input  wire logic                                clk_read,
    input  wire logic                                rst,
    input  wire logic                                wb_cyc,
    input  wire logic                                wb_stb,
    input  wire logic                                wb_we,
    input  wire logic [color_pkg::WB_ADDR_BITS-1:0]  wb_adr,
    input  wire logic [color_pkg::WB_DATA_BITS-1:0]  wb_dat_w,
    output logic      [color_pkg::WB_DATA_BITS-1:0]  wb_dat_r,
    output logic                                     wb_ack,
    output color_pkg::video_t                        video
);

    color_pkg::raster_t      raster;
    color_pkg::pixel_write_t pixel;
    color_pkg::color12_t     read_data;
    color_pkg::fb_select_t   back_buffer;
    logic                    pixel_we;
    logic                    swap_request;
    logic                    swap_busy;
    logic                    swap;

    // Read domain
    raster_timer raster_timer_i (
        .clk_read (clk_read),
        .rst      (rst),
        .raster   (raster)
    );

    // Write domain, vblank crosses in here
    swap_sequencer swap_sequencer_i (
        .clk_write    (clk_write),
        .rst          (rst),
        .swap_request (swap_request),
        .vblank       (raster.vblank),
        .swap_busy    (swap_busy),
        .swap         (swap)
    );

    wb_pixel_port wb_pixel_port_i (
        .clk_write    (clk_write),
        .rst          (rst),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .swap_busy    (swap_busy),
        .back_buffer  (back_buffer),
        .pixel        (pixel),
        .pixel_we     (pixel_we),
        .swap_request (swap_request)
    );

    double_framebuffer #(
        .FB_WIDTH  (color_pkg::H_ACTIVE),
        .FB_HEIGHT (color_pkg::V_ACTIVE)
    ) double_framebuffer_i (
        .clk_write   (clk_write),
        .clk_read    (clk_read),
        .rst         (rst),
        .swap        (swap),
        .pixel_we    (pixel_we),
        .pixel       (pixel),
        .read_x      (raster.x),
        .read_y      (raster.y),
        .read_data   (read_data),
        .back_buffer (back_buffer)
    );

    video_output video_output_i (
        .clk_read    (clk_read),
        .rst         (rst),
        .raster      (raster),
        .pixel_color (read_data),
        .video       (video)
    );

endmodule

`default_nettype wire

// ==== bench/video_subsystem_assert.sv ====
`default_nettype none
`timescale 1ns/1ps

module video_subsystem_assert (
    input wire logic              clk_read,
    input wire logic              clk_write,
    input wire logic              rst,
    input wire color_pkg::video_t video,
    input wire logic              wb_ack
);

    localparam int HSYNC_WIDTH = color_pkg::H_SYNC_END - color_pkg::H_SYNC_START;

    logic [7:0] hsync_len;   // High cycles of the current pulse

    always_ff @(posedge clk_read or posedge rst) begin
        if (rst) begin
            hsync_len <= '0;
        end else if (video.hsync) begin
            hsync_len <= hsync_len + 1'b1;
        end else begin
            hsync_len <= '0;
        end
    end

    hsync_width: assert property (@(posedge clk_read) disable iff (rst)
        $fell(video.hsync) |-> (hsync_len == 8'(HSYNC_WIDTH)))
        else $error("hsync pulse lasted %0d cycles", hsync_len);

    // Black outside the picture
    blank_black: assert property (@(posedge clk_read) disable iff (rst)
        !video.active |-> (video.color == '0))
        else $error("colour %h while not active", video.color);

    ack_single: assert property (@(posedge clk_write) disable iff (rst)
        wb_ack |=> !wb_ack)
        else $error("wb_ack high for two cycles");

endmodule

bind video_subsystem video_subsystem_assert video_subsystem_assert_i (
    .clk_read  (clk_read),
    .clk_write (clk_write),
    .rst       (rst),
    .video     (video),
    .wb_ack    (wb_ack)
);

`default_nettype wire

// ==== bench/tb_video_subsystem.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_video_subsystem;

    localparam int FB_PIXELS      = color_pkg::H_ACTIVE * color_pkg::V_ACTIVE;
    localparam int FRAME_CYCLES   = color_pkg::H_TOTAL * color_pkg::V_TOTAL;
    localparam int TIMEOUT_CYCLES = 11 * FRAME_CYCLES + 14000;  // Frames plus fill time
    localparam logic [15:0] CTRL_ADR = 16'h8000;

    logic                                   clk_write;
    logic                                   clk_read;
    logic                                   rst;
    logic                                   wb_cyc;
    logic                                   wb_stb;
    logic                                   wb_we;
    logic [color_pkg::WB_ADDR_BITS-1:0]     wb_adr;
    logic [color_pkg::WB_DATA_BITS-1:0]     wb_dat_w;
    logic [color_pkg::WB_DATA_BITS-1:0]     wb_dat_r;
    logic                                   wb_ack;
    color_pkg::video_t                      video;

    // Shadow copies of both buffers
    color_pkg::color12_t   shadow_a [0:FB_PIXELS-1];
    color_pkg::color12_t   shadow_b [0:FB_PIXELS-1];
    color_pkg::fb_select_t front_buf;

    int   seed;
    int   read_cycles = 0;
    int   frames_wanted;
    int   frames_done;
    logic comparing;
    int   col;
    int   row;
    int   vsync_lines;
    logic prev_active;
    logic prev_hsync;
    logic prev_vsync;

    video_subsystem dut_i (
        .clk_write (clk_write),
        .clk_read  (clk_read),
        .rst       (rst),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .video     (video)
    );

    initial begin
        clk_read = 1'b0;
        forever #20 clk_read = ~clk_read;
    end

    initial begin
        clk_write = 1'b0;
        forever #15 clk_write = ~clk_write;
    end

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic report_mismatch(input string msg);
        abort_run($sformatf("FAILED at %0t ns: %s", $time, msg));
    endtask

    task automatic check_color(input color_pkg::color12_t actual,
                               input color_pkg::color12_t expected,
                               input string where, input int x, input int y);
        if (actual !== expected) begin
            report_mismatch($sformatf("%s at (%0d,%0d) colour %h, expected %h",
                                      where, x, y, actual, expected));
        end
    endtask

    task automatic check_status(input logic [color_pkg::WB_DATA_BITS-1:0] actual,
                                input logic [color_pkg::WB_DATA_BITS-1:0] expected,
                                input string where);
        if (actual !== expected) begin
            report_mismatch($sformatf("%s status %h, expected %h", where, actual, expected));
        end
    endtask

    task automatic check_video(input color_pkg::video_t actual,
                               input color_pkg::video_t expected, input string where);
        if (actual !== expected) begin
            report_mismatch($sformatf("%s video %h, expected %h", where, actual, expected));
        end
    endtask

    function automatic color_pkg::fb_select_t other_buffer(input color_pkg::fb_select_t b);
        return (b == color_pkg::FB_A) ? color_pkg::FB_B : color_pkg::FB_A;
    endfunction

    // Expected pixel from the shadow of the displayed buffer
    function automatic color_pkg::color12_t expected_color(input int x, input int y);
        int idx;
        idx = y * color_pkg::H_ACTIVE + x;
        if (front_buf == color_pkg::FB_A) begin
            return shadow_a[idx];
        end else begin
            return shadow_b[idx];
        end
    endfunction

    function automatic logic [color_pkg::WB_DATA_BITS-1:0] expected_status(
        input logic busy, input color_pkg::fb_select_t back);
        logic [color_pkg::WB_DATA_BITS-1:0] word;
        word    = '0;
        word[0] = busy;
        word[1] = (back == color_pkg::FB_B);
        return word;
    endfunction

    // One classic cycle, held until ack
    task automatic wb_access(input logic we, input logic [15:0] adr, input logic [31:0] dat,
                             output logic [31:0] rdata, output int waits);
        @(negedge clk_write);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = dat;
        waits    = 0;
        do begin
            @(negedge clk_write);
            waits++;
        end while (!wb_ack);
        rdata  = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic store_shadow(input int x, input int y, input color_pkg::color12_t c);
        if (other_buffer(front_buf) == color_pkg::FB_A) begin
            shadow_a[y * color_pkg::H_ACTIVE + x] = c;
        end else begin
            shadow_b[y * color_pkg::H_ACTIVE + x] = c;
        end
    endtask

    task automatic fill_back_buffer();
        logic [31:0]         rdata;
        int                  waits;
        color_pkg::color12_t c;
        for (int y = 0; y < color_pkg::V_ACTIVE; y++) begin
            for (int x = 0; x < color_pkg::H_ACTIVE; x++) begin
                c = color_pkg::color12_t'($random(seed));
                wb_access(1'b1, {1'b0, 7'(y), 8'(x)}, {20'b0, c}, rdata, waits);
                store_shadow(x, y, c);
            end
        end
    endtask

    // Poll until the sequencer is idle, then follow the swap
    task automatic wait_swap_done();
        logic [31:0] word;
        int          waits;
        do begin
            wb_access(1'b0, CTRL_ADR, 32'h0, word, waits);
        end while (word[0]);
        front_buf = other_buffer(front_buf);
        check_status(word, expected_status(1'b0, other_buffer(front_buf)), "After swap");
    endtask

    task automatic request_swap();
        logic [31:0] word;
        int          waits;
        wb_access(1'b1, CTRL_ADR, 32'h1, word, waits);
        wait_swap_done();
    endtask

    task automatic capture_frame();
        frames_wanted = frames_done + 1;
        wait (frames_done >= frames_wanted);
    endtask

    // Frame capture and compare, outputs settle after the rising edge
    always @(negedge clk_read) begin
        if (!rst) begin
            if (!video.active) begin
                check_color(video.color, '0, "Blanking", col, row);
            end
            if (video.hsync && !prev_hsync && video.vsync) begin
                vsync_lines++;
            end
            if (video.vsync && !prev_vsync) begin
                if (comparing) begin
                    if (row != color_pkg::V_ACTIVE) begin
                        report_mismatch($sformatf("frame had %0d active lines", row));
                    end
                    frames_done++;
                end
                comparing   = (frames_done < frames_wanted);
                row         = 0;
                col         = 0;
                vsync_lines = 0;
            end
            if (!video.vsync && prev_vsync && vsync_lines != 2) begin
                report_mismatch($sformatf("vsync spanned %0d lines", vsync_lines));
            end
            if (video.active) begin
                if (comparing) begin
                    check_color(video.color, expected_color(col, row), "Pixel", col, row);
                end
                col++;
            end else if (prev_active) begin
                if (comparing && col != color_pkg::H_ACTIVE) begin
                    report_mismatch($sformatf("line %0d had %0d active pixels", row, col));
                end
                row++;
                col = 0;
            end
            prev_active = video.active;
            prev_hsync  = video.hsync;
            prev_vsync  = video.vsync;
        end
    end

    always @(posedge clk_read) begin
        read_cycles++;
        if (read_cycles >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("Timed out after %0d clk_read cycles", read_cycles));
        end
    end

    initial begin
        logic [31:0]         word;
        int                  waits;
        color_pkg::color12_t late_color;
        seed          = 38434;
        front_buf     = color_pkg::FB_A;
        frames_wanted = 0;
        frames_done   = 0;
        comparing     = 1'b0;
        col           = 0;
        row           = 0;
        vsync_lines   = 0;
        prev_active   = 1'b0;
        prev_hsync    = 1'b0;
        prev_vsync    = 1'b0;
        rst           = 1'b1;
        wb_cyc        = 1'b0;
        wb_stb        = 1'b0;
        wb_we         = 1'b0;
        wb_adr        = '0;
        wb_dat_w      = '0;
        repeat (4) @(posedge clk_read);
        @(negedge clk_read);
        check_video(video, '0, "During reset");
        rst = 1'b0;

        wb_access(1'b0, CTRL_ADR, 32'h0, word, waits);
        check_status(word, expected_status(1'b0, color_pkg::FB_B), "After reset");

        fill_back_buffer();     // B
        request_swap();
        capture_frame();

        // A fills while B stays on screen
        fork
            fill_back_buffer();
            capture_frame();
        join

        request_swap();
        capture_frame();

        // Pixel write right behind a swap request
        wb_access(1'b1, CTRL_ADR, 32'h1, word, waits);
        late_color = color_pkg::color12_t'($random(seed));
        wb_access(1'b1, {1'b0, 7'd55, 8'd37}, {20'b0, late_color}, word, waits);
        if (waits < 4) begin
            report_mismatch($sformatf("pixel write acked after %0d cycles during swap", waits));
        end
        wait_swap_done();
        store_shadow(37, 55, late_color);
        request_swap();
        capture_frame();

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
verilog/color_pkg.sv
verilog/raster_timer.sv
verilog/swap_sequencer.sv
verilog/wb_pixel_port.sv
verilog/double_framebuffer.sv
verilog/video_output.sv
verilog/video_subsystem.sv
bench/video_subsystem_assert.sv
bench/tb_video_subsystem.sv

// ==== Makefile ====
# Verilator simulation of the video subsystem

VERILATOR ?= verilator
TOP       ?= tb_video_subsystem
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
SIM_BIN   ?= sim_video

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG SIM_BIN"

test:
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o $(SIM_BIN)
	./$(BUILD_DIR)/$(SIM_BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
